/* logic/cpu_state_pkg.sv */
// CPU state control types: cycle state vector, instruction flags and AD bus word
package cpu_state_pkg;

	// One-hot cycle state; the same layout carries the next-state request
	typedef struct packed {
		logic k1;	// Fetch, first word
		logic k2;	// Fetch, second word
		logic p0;	// Idle / panel wait
		logic p1;	// Second word fetch
		logic p2;	// Effective address
		logic p3;	// Modification
		logic p4;	// Pre-index
		logic p5;	// Operand read
		logic wp;	// Execute, prepare
		logic wa;	// Execute, A
		logic we;	// Execute, E
		logic wr;	// Execute, read
		logic w_s;	// Execute, shift (W&)
		logic wz;	// Execute, Z
		logic wx;	// Execute, X
		logic wm;	// Execute, I/O and control
		logic ww;	// Execute, write
		logic i1;	// Interrupt phase 1
		logic i2;	// Interrupt phase 2
		logic i3;	// Interrupt phase 3, register stack
		logic i4;	// Interrupt phase 4, vector read
		logic i5;	// Interrupt phase 5, return
	} state_t;

	typedef struct packed {
		logic lip;	// Return from interrupt
		logic sp;	// Load process context
		logic in;	// Input
		logic ou;	// Output
		logic mcl;	// Master clear
		logic gi;	// Generate interrupt
		logic fi;	// Flags to interrupt register
		logic is;	// Bit set in memory
		logic exl;	// Extracode
		logic pufa;	// Wide or FP instruction
	} op_t;

	// AD word seen as an interrupt vector during I phases
	typedef struct packed {
		logic [8:0] pad;	// Always zero
		logic phase_a;	// I1/I4/I5 marker
		logic phase_b;	// I1/I5, or I4 with request
		logic spare;
		logic wide;	// Wide/FP op behind the request
		logic [2:0] ir_code;	// Interrupt source
	} ad_vec_t;

	typedef union packed {
		logic [15:0] raw;	// Plain address
		ad_vec_t vec;
	} ad_word_u;

	localparam state_t STATE_RESET = '{p0: 1'b1, default: 1'b0};	// P0 only

endpackage

/* logic/sys_bus_pkg.sv */
// System bus side: driver enables, reply lines and alarm timer defaults
package sys_bus_pkg;

	localparam int DDT_W = 16;	// Data bus width
	localparam int DDT_GI_BIT = 0;	// Data bit carried with a generated interrupt

	// Bus driver enables raised by the state unit
	typedef struct packed {
		logic df;	// Fetch
		logic dr;	// Read
		logic dw;	// Write
		logic din;	// Interrupt
		logic ds;	// Send
		logic dmcl;	// Software reset
		logic [DDT_W-1:0] ddt;	// Data word
	} bus_drv_t;

	// Replies from the bus
	typedef struct packed {
		logic zw;	// Grant
		logic ren;	// EN
		logic rok;	// OK
		logic rpe;	// Parity error
	} bus_rsp_t;

	// Missing reply detection, in clock cycles
	localparam int ALARM_DLY_DEF = 32;	// Wait before alarm
	localparam int ALARM_LEN_DEF = 4;	// Alarm pulse length

endpackage

/* logic/strobgen.sv */
// Strobe generator: steps each CPU cycle through strob1/strob1b/strob2/strob2b and got
`timescale 1ns/10ps

module strobgen (
	input logic __clk,
	input logic clo,
	input logic mode,	// Step mode
	input logic step,	// Step key
	input logic long_cycle,	// Needs strob2 phase
	input logic zwzg,	// Bus transaction open
	input logic ok_s,	// Reply received
	input logic talarm,	// Reply timeout
	output logic strob1,
	output logic strob1b,
	output logic strob2,
	output logic strob2b,
	output logic got,	// End of cycle
	output logic ldstate,	// Load next state
	output logic gotst1	// Bus request point
);

	localparam logic [2:0] ST_WAIT = 3'd0;	// Between cycles
	localparam logic [2:0] ST_S1 = 3'd1;
	localparam logic [2:0] ST_S1B = 3'd2;
	localparam logic [2:0] ST_S2 = 3'd3;
	localparam logic [2:0] ST_S2B = 3'd4;
	localparam logic [2:0] ST_GOT = 3'd5;

	logic [2:0] st;
	logic [2:0] st_nxt;
	logic run;	// Set one clock after reset release
	logic step_q;
	logic step_rise;
	logic bus_hold;	// Stretch strob1b

	assign step_rise = step & ~step_q;
	assign bus_hold = zwzg & ~ok_s & ~talarm;

	always_comb begin
		st_nxt = st;
		case (st)
			ST_WAIT: if (run & (~mode | step_rise)) st_nxt = ST_S1;
			ST_S1: st_nxt = ST_S1B;
			ST_S1B: begin
				if (!bus_hold) begin
					st_nxt = long_cycle ? ST_S2 : ST_GOT;
				end
			end
			ST_S2: st_nxt = ST_S2B;
			ST_S2B: st_nxt = ST_GOT;
			ST_GOT: st_nxt = mode ? ST_WAIT : ST_S1;	// Step mode parks
			default: st_nxt = ST_WAIT;
		endcase
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			st <= ST_WAIT;
			run <= 1'b0;
			step_q <= 1'b0;
		end else begin
			st <= st_nxt;
			run <= 1'b1;
			step_q <= step;	// Edge detect, one press one cycle
		end
	end

	assign strob1 = (st == ST_S1);
	assign strob1b = (st == ST_S1B);
	assign strob2 = (st == ST_S2);
	assign strob2b = (st == ST_S2B);
	assign got = (st == ST_GOT);
	assign ldstate = (st == ST_GOT);	// Same pulse as got
	assign gotst1 = (st == ST_S1);	// New state valid, request bus here

endmodule

/* logic/px.sv */
// P-X state unit: cycle state registers, interrupt phases, bus drivers, halt and alarm
`timescale 1ns/10ps

module px #(
	parameter bit AWP_PRESENT = 1'b0,	// Hardware FP present
	parameter bit STOP_ON_NOMEM = 1'b1	// Halt on missing memory
) (
	input logic __clk,
	input logic clo,
	input cpu_state_pkg::state_t enter,	// Next-state request
	input logic sp0,	// Set P0
	input logic sp1,	// Set P1
	input logic si1,	// Set I1
	input cpu_state_pkg::op_t op,
	input logic przerw,	// Interrupt pending
	input logic przerw_z,	// Interrupt accepted
	input logic pp,
	input logic lg_0,	// Group counter 0
	input logic lg_3,	// Group counter 3
	input logic efp,	// FP op without hardware
	input logic laduj,	// Panel load
	input logic k2_bin_store,
	input logic k2fetch,
	input logic stop,	// Panel stop
	input logic [2:0] ir,	// Interrupt source code
	input logic rpe,	// Parity error reply
	input logic strob1,
	input logic strob1b,
	input logic strob2,
	input logic strob2b,
	input logic got,
	input logic ldstate,
	input logic zwzg,
	input logic talarm,
	output cpu_state_pkg::state_t state,
	output logic long_cycle,
	output logic zgi_j,	// Bus needed in this state
	output logic zgi_set,	// Immediate bus request
	output sys_bus_pkg::bus_drv_t drv,
	output cpu_state_pkg::ad_word_u dad,
	output logic hlt_n,
	output logic awaria,
	output logic b_p0,	// Missing memory source
	output logic b_parz	// Parity error source
);
	import cpu_state_pkg::*;
	import sys_bus_pkg::*;

	logic soft_fp;	// Soft FP in progress
	logic ef;
	logic exr;	// Extended request
	logic lipsp;
	logic ei1;
	logic ei2;
	logic ei3;
	logic ei4;
	logic ei5;
	logic k2fbs;
	logic rd;	// Read rule
	logic wr_rq;	// Write rule
	logic rw;
	logic wm_gi;
	logic ad_ad;	// Vector code onto AD
	logic bar;	// Bar addressing in I3
	logic bus_act;
	logic strob_any;
	logic awaria_set;

	assign ef = efp & ~AWP_PRESENT;	// Emulate FP only without hardware
	assign exr = soft_fp | ef | op.exl;
	assign lipsp = op.lip | op.sp;

	// Interrupt phase sequencing
	assign ei1 = (exr | op.lip) & pp;
	assign ei2 = state.i1 & przerw_z;
	assign ei3 = (~przerw_z & przerw & state.i1) | (state.i1 & exr) | (op.sp & pp)
		| state.i2 | (state.i5 & op.lip)
		| (~lipsp & ~lg_0 & state.i3)	// Next register, plain
		| (state.i3 & lipsp & ~lg_3);	// Next register, LIP/SP
	assign ei4 = state.i3 & lg_0;
	assign ei5 = state.i4 | (op.lip & state.i1);

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			state <= STATE_RESET;
		end else begin
			if (ldstate) begin
				state <= enter;	// K, P and W phases
				state.i1 <= ei1;
				state.i2 <= ei2;
				state.i3 <= ei3;
				state.i4 <= ei4;
				state.i5 <= ei5;
			end
			if (sp0) state.p0 <= 1'b1;	// Set strobes win over load
			if (sp1) state.p1 <= 1'b1;
			if (si1) state.i1 <= 1'b1;
		end
	end

	// JK flop, set on ef and cleared by I5, toggled at end of cycle
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			soft_fp <= 1'b0;
		end else if (got) begin
			case ({ef, state.i5})
				2'b01: soft_fp <= 1'b0;
				2'b10: soft_fp <= 1'b1;
				2'b11: soft_fp <= ~soft_fp;
				default: soft_fp <= soft_fp;
			endcase
		end
	end

	assign long_cycle = state.p2 | state.p3 | state.p4 | state.wp | state.wa | state.we
		| state.w_s | state.wz | state.wx | (state.k2 & laduj);

	assign k2fbs = k2_bin_store | k2fetch;
	assign zgi_j = state.k1 | state.p1 | state.p5 | state.wr | state.ww | state.wm
		| state.i1 | state.i2 | state.i3 | state.i4 | state.i5 | k2fbs;
	assign zgi_set = si1 | sp1;	// Interrupt or panel entry

	// Bus direction rules
	assign rd = k2fetch | state.p1 | state.p5 | state.wr | state.i1
		| (state.i3 & lipsp) | state.i4;
	assign wr_rq = state.ww | state.i5 | (state.i3 & (przerw | exr)) | k2_bin_store;
	assign rw = rd ^ wr_rq;
	assign wm_gi = state.wm & op.gi;

	always_comb begin
		drv = '0;
		drv.df = zwzg & (state.k1 | state.i2 | (op.in & state.wm));
		drv.dr = zwzg & rd;
		drv.dw = zwzg & wr_rq;
		drv.din = zwzg & wm_gi;
		drv.ds = zwzg & op.ou & state.wm;
		drv.dmcl = zwzg & op.mcl & state.wm;
		drv.ddt[DDT_GI_BIT] = zwzg & wm_gi;	// Interrupt data word
	end

	// Interrupt vector on AD, raw address zero otherwise
	assign ad_ad = zwzg & state.i4 & soft_fp;

	always_comb begin
		dad.raw = '0;
		dad.vec.phase_a = zwzg & (state.i1 | state.i4 | state.i5);
		dad.vec.phase_b = zwzg & (state.i1 | (state.i4 & exr) | state.i5);
		dad.vec.wide = ad_ad & op.pufa;
		dad.vec.ir_code = ad_ad ? ir : 3'd0;
	end

	// Alarm sources
	assign strob_any = strob1 | strob1b | strob2 | strob2b;
	assign bar = zwzg & state.i3 & op.sp;
	assign b_parz = strob_any & rpe & rd;	// Only inside a read cycle
	assign b_p0 = rw & talarm;
	assign awaria_set = (b_parz | b_p0) & ~bar;

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			awaria <= 1'b0;
		end else if (stop) begin
			awaria <= 1'b0;
		end else if (awaria_set) begin
			awaria <= 1'b1;
		end
	end

	assign bus_act = zwzg & rw;

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			hlt_n <= 1'b0;
		end else if (!bus_act) begin
			hlt_n <= 1'b0;	// Bus idle
		end else if (awaria_set & STOP_ON_NOMEM) begin
			hlt_n <= 1'b1;
		end else if (strob1) begin
			hlt_n <= ~stop;
		end
	end

endmodule

/* logic/ifctl.sv */
// Bus interface control: request flip-flop, grant, reply capture and alarm timer
`timescale 1ns/10ps

module ifctl #(
	parameter int ALARM_DLY_TICKS = sys_bus_pkg::ALARM_DLY_DEF,	// Wait before alarm
	parameter int ALARM_TICKS = sys_bus_pkg::ALARM_LEN_DEF	// Alarm length
) (
	input logic __clk,
	input logic clo,
	input logic gotst1,	// Cycle start
	input logic zgi_j,	// State needs the bus
	input logic zgi_set,	// Immediate request
	input sys_bus_pkg::bus_rsp_t rsp,
	output logic zg,	// Bus request
	output logic zwzg,	// Requested and granted
	output logic ok_s,	// Reply seen
	output logic talarm	// No reply in time
);

	localparam int DLY_W = $clog2(ALARM_DLY_TICKS + 1);
	localparam int LEN_W = $clog2(ALARM_TICKS + 1);

	logic oken;	// OK or EN
	logic alarm_go;
	logic [DLY_W-1:0] wait_cnt;
	logic [LEN_W-1:0] len_cnt;

	assign oken = rsp.ren | rsp.rok;
	assign zwzg = zg & rsp.zw;

	// Clear wins so a finished transfer does not re-request
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			zg <= 1'b0;
		end else if (ok_s | talarm) begin
			zg <= 1'b0;
		end else if (zgi_set | (gotst1 & zgi_j)) begin
			zg <= 1'b1;
		end
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			ok_s <= 1'b0;
		end else begin
			ok_s <= zwzg & oken;
		end
	end

	// Unanswered grant counter
	assign alarm_go = zwzg & ~oken & ~talarm
		& (wait_cnt == DLY_W'(ALARM_DLY_TICKS - 1));

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			wait_cnt <= '0;
		end else if (!zwzg || oken || talarm) begin
			wait_cnt <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			talarm <= 1'b0;
			len_cnt <= '0;
		end else if (alarm_go) begin
			talarm <= 1'b1;
			len_cnt <= '0;
		end else if (talarm) begin
			if (len_cnt == LEN_W'(ALARM_TICKS - 1)) talarm <= 1'b0;	// Pulse done
			len_cnt <= len_cnt + 1'b1;
		end
	end

endmodule

/* logic/cpu_ctl.sv */
// CPU state control top: strobe generator, state unit and bus interface control
`timescale 1ns/10ps

module cpu_ctl #(
	parameter bit AWP_PRESENT = 1'b0,
	parameter bit STOP_ON_NOMEM = 1'b1,
	parameter int ALARM_DLY_TICKS = sys_bus_pkg::ALARM_DLY_DEF,
	parameter int ALARM_TICKS = sys_bus_pkg::ALARM_LEN_DEF
) (
	input logic __clk,
	input logic clo,
	input cpu_state_pkg::state_t enter,
	input logic sp0,
	input logic sp1,
	input logic si1,
	input cpu_state_pkg::op_t op,
	input logic przerw,
	input logic przerw_z,
	input logic pp,
	input logic lg_0,
	input logic lg_3,
	input logic [2:0] ir,
	input logic efp,
	input logic laduj,
	input logic k2_bin_store,
	input logic k2fetch,
	input logic mode,
	input logic step,
	input logic stop,
	input sys_bus_pkg::bus_rsp_t rsp,
	output cpu_state_pkg::state_t state,
	output logic got,
	output logic ldstate,
	output logic zg,
	output sys_bus_pkg::bus_drv_t drv,
	output cpu_state_pkg::ad_word_u dad,
	output logic hlt_n,
	output logic awaria,
	output logic b_p0,
	output logic b_parz
);

	logic strob1;
	logic strob1b;
	logic strob2;
	logic strob2b;
	logic gotst1;
	logic long_cycle;
	logic zgi_j;
	logic zgi_set;
	logic zwzg;
	logic ok_s;
	logic talarm;

	strobgen u_strobgen (
		.__clk(__clk), .clo(clo), .mode(mode), .step(step), .long_cycle(long_cycle),
		.zwzg(zwzg), .ok_s(ok_s), .talarm(talarm),
		.strob1(strob1), .strob1b(strob1b), .strob2(strob2), .strob2b(strob2b),
		.got(got), .ldstate(ldstate), .gotst1(gotst1)
	);

	px #(
		.AWP_PRESENT(AWP_PRESENT),
		.STOP_ON_NOMEM(STOP_ON_NOMEM)
	) u_px (
		.__clk(__clk), .clo(clo), .enter(enter), .sp0(sp0), .sp1(sp1), .si1(si1),
		.op(op), .przerw(przerw), .przerw_z(przerw_z), .pp(pp), .lg_0(lg_0),
		.lg_3(lg_3), .efp(efp), .laduj(laduj), .k2_bin_store(k2_bin_store),
		.k2fetch(k2fetch), .stop(stop), .ir(ir), .rpe(rsp.rpe),
		.strob1(strob1), .strob1b(strob1b), .strob2(strob2), .strob2b(strob2b),
		.got(got), .ldstate(ldstate), .zwzg(zwzg), .talarm(talarm),
		.state(state), .long_cycle(long_cycle), .zgi_j(zgi_j), .zgi_set(zgi_set),
		.drv(drv), .dad(dad), .hlt_n(hlt_n), .awaria(awaria), .b_p0(b_p0),
		.b_parz(b_parz)
	);

	ifctl #(
		.ALARM_DLY_TICKS(ALARM_DLY_TICKS),
		.ALARM_TICKS(ALARM_TICKS)
	) u_ifctl (
		.__clk(__clk), .clo(clo), .gotst1(gotst1), .zgi_j(zgi_j), .zgi_set(zgi_set),
		.rsp(rsp), .zg(zg), .zwzg(zwzg), .ok_s(ok_s), .talarm(talarm)
	);

endmodule

/* testbench/cpu_ctl_sva.sv */
// Strobe order and bus protocol assertions, bound into the CPU state control top
`timescale 1ns/10ps

module cpu_ctl_sva #(
	parameter int DLY = 1	// Reply wait before alarm
) (
	input logic __clk,
	input logic clo,
	input logic strob1,
	input logic strob1b,
	input logic strob2,
	input logic strob2b,
	input logic got,
	input logic zg,
	input logic zwzg,
	input logic ok_s,
	input logic talarm
);

	a_s1_then_s1b: assert property (@(posedge __clk) disable iff (clo)
		strob1 |=> strob1b) else $error("strob1 not followed by strob1b");

	a_got_alone: assert property (@(posedge __clk) disable iff (clo)
		got |-> !(strob1 | strob1b | strob2 | strob2b)) else $error("got overlaps a strobe");

	a_zg_drop: assert property (@(posedge __clk) disable iff (clo)
		ok_s |=> !zg) else $error("zg still high after ok_s");	// Clear wins over set

	// Grant open over the whole wait window
	a_alarm_src: assert property (@(posedge __clk) disable iff (clo)
		$rose(talarm) |-> $past(zwzg) && $past(zwzg, DLY))
		else $error("talarm rose without zwzg over the wait window");

endmodule

bind cpu_ctl cpu_ctl_sva #(.DLY(ALARM_DLY_TICKS)) u_sva (.*);

/* testbench/cpu_ctl_tb.sv */
// CPU state control testbench: random cycles and bus replies checked against a reference model
`timescale 1ns/10ps

module cpu_ctl_tb;
	import cpu_state_pkg::*;
	import sys_bus_pkg::*;

	localparam int ALARM_DLY = 8;	// Reply wait before alarm
	localparam int ALARM_LEN = 2;	// Alarm pulse length

	logic __clk = 1'b0;
	logic clo = 1'b1;
	state_t enter = STATE_RESET;
	logic sp0 = 1'b0, sp1 = 1'b0, si1 = 1'b0;
	op_t op = '0;
	logic przerw = 1'b0, przerw_z = 1'b0, pp = 1'b0, lg_0 = 1'b0, lg_3 = 1'b0;
	logic [2:0] ir = '0;
	logic efp = 1'b0, laduj = 1'b0, k2_bin_store = 1'b0, k2fetch = 1'b0;
	logic mode = 1'b0, step = 1'b0, stop = 1'b0;
	bus_rsp_t rsp = '0;
	state_t state;
	logic got, ldstate, zg, hlt_n, awaria, b_p0, b_parz;
	bus_drv_t drv;
	ad_word_u dad;

	logic clo_req = 1'b1, mode_req = 1'b0, step_req = 1'b0, stop_req = 1'b0;	// Next edge
	state_t m_state = STATE_RESET;	// Model of K, P, W registers
	state_t p_enter;
	logic m_aw = 1'b0;
	logic m_sfp = 1'b0;	// Soft FP flop
	logic in_reset = 1'b1;
	logic par_on = 1'b0;	// Random parity errors
	logic p_ld = 0, p_sp0 = 0, p_sp1 = 0, p_si1 = 0, p_got = 0, p_stop = 0;
	logic p_efp = 0, p_i5 = 0, p_al = 0;
	logic p_idle = 1, p_awset = 0, s_zg = 0, s_zw = 0;
	logic zwzg_t, rd, wr;
	logic armed = 0, replied = 0, no_rep = 0;	// Bus responder
	int gnt_wait, rep_wait, unans = 0, ok_age = 0, alarms = 0, alarm_left = 0;
	int checks = 0, errors = 0;

	cpu_ctl #(
		.AWP_PRESENT(1'b0),
		.STOP_ON_NOMEM(1'b1),
		.ALARM_DLY_TICKS(ALARM_DLY),
		.ALARM_TICKS(ALARM_LEN)
	) DUT (.*);

	always #50 __clk = ~__clk;

	function automatic logic rd_rule(state_t s);
		return k2fetch | s.p1 | s.p5 | s.wr | s.i1 | (s.i3 & (op.lip | op.sp)) | s.i4;
	endfunction

	function automatic logic wr_rule(state_t s, logic x);
		return s.ww | s.i5 | (s.i3 & (przerw | x)) | k2_bin_store;
	endfunction

	task automatic check(string name, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic drive_inputs();
		sp0 <= ($urandom % 40) == 0;
		sp1 <= ($urandom % 40) == 0;
		si1 <= ($urandom % 40) == 0;
		if (p_got) begin	// New request for the next cycle
			enter <= state_t'(22'(1) << (5 + $urandom % 17));
			op <= op_t'($urandom);
			{przerw, przerw_z, pp, lg_0, lg_3, laduj} <= 6'($urandom);
			efp <= ($urandom % 8) == 0;
			k2fetch <= ($urandom % 8) == 0;
			k2_bin_store <= ($urandom % 8) == 0;
			ir <= 3'($urandom);
		end
		rsp.rpe <= par_on && (($urandom % 16) == 0);
		rsp.ren <= 1'b0;
		rsp.rok <= 1'b0;
		if (!s_zg) begin
			rsp.zw <= 1'b0;
			armed = 0;
			replied = 0;
		end else if (!s_zw) begin
			if (!armed) begin
				armed = 1;
				gnt_wait = $urandom % 4;
				rep_wait = $urandom % 5;
				no_rep = ($urandom % 4) == 0;	// Left to the alarm timer
			end
			if (gnt_wait == 0) rsp.zw <= 1'b1;
			else gnt_wait--;
		end else if (!no_rep && !replied) begin
			if (rep_wait == 0) begin
				if ($urandom % 2) rsp.rok <= 1'b1;
				else rsp.ren <= 1'b1;
				replied = 1;
			end else rep_wait--;
		end
	endtask

	task automatic tick();
		logic exr_m;
		logic vec_on;
		logic exp_p0;
		logic exp_parz;
		@(posedge __clk);
		clo <= clo_req;
		mode <= mode_req;
		step <= step_req;
		stop <= stop_req;
		if (!in_reset) begin
			if (p_ld) m_state = p_enter;
			if (p_sp0) m_state.p0 = 1'b1;
			if (p_sp1) m_state.p1 = 1'b1;
			if (p_got) begin	// Set by efp, cleared by I5, both toggles
				if (p_efp & p_i5) m_sfp = ~m_sfp;
				else if (p_efp) m_sfp = 1'b1;
				else if (p_i5) m_sfp = 1'b0;
			end
			if (p_stop) m_aw = 1'b0;
			else if (p_awset) m_aw = 1'b1;
			drive_inputs();
		end
		@(negedge __clk);
		zwzg_t = zg & rsp.zw;
		exr_m = m_sfp | efp | op.exl;
		rd = rd_rule(state);
		wr = wr_rule(state, exr_m);
		vec_on = zwzg_t & state.i4 & m_sfp;
		exp_p0 = (alarm_left > 0) & (rd ^ wr);
		exp_parz = rsp.rpe & rd & ~got;	// Free running, strobes fill all but got
		if (in_reset) begin
			check("state", STATE_RESET, state);
			check("got", 0, got);
			check("zg", 0, zg);
			check("drv", 0, drv);
			check("awaria", 0, awaria);
			check("b_p0", 0, b_p0);
		end else begin
			check("state.kpw", m_state[21:5], state[21:5]);
			if (p_si1) check("state.i1", 1, state.i1);
			check("ldstate", got, ldstate);
			check("drv.dr", zwzg_t & rd, drv.dr);
			check("drv.dw", zwzg_t & wr, drv.dw);
			if (!zwzg_t) check("drv", 0, drv);
			check("dad.phase_a", zwzg_t & (state.i1 | state.i4 | state.i5), dad.vec.phase_a);
			check("dad.phase_b", zwzg_t & (state.i1 | (state.i4 & exr_m) | state.i5),
				dad.vec.phase_b);
			check("dad.ir_code", vec_on ? ir : 3'd0, dad.vec.ir_code);
			check("dad.wide", vec_on & op.pufa, dad.vec.wide);
			check("awaria", m_aw, awaria);
			if (p_idle) check("hlt_n", 0, hlt_n);
			else if (p_awset) check("hlt_n", 1, hlt_n);	// Halt on missing memory
			if (ok_age == 2 || p_al) check("zg", 0, zg);
			check("b_p0", exp_p0, b_p0);
			check("b_parz", exp_parz, b_parz);
			if (exp_p0) alarms++;
		end
		p_al = alarm_left > 0;
		ok_age = (zwzg_t & (rsp.ren | rsp.rok)) ? 1 : (ok_age == 1 ? 2 : 0);
		unans = (zwzg_t & ~rsp.ren & ~rsp.rok) ? unans + 1 : 0;
		if (alarm_left > 0) alarm_left--;
		else if (unans == ALARM_DLY) alarm_left = ALARM_LEN;
		p_ld = ldstate;
		p_enter = enter;
		{p_sp0, p_sp1, p_si1, p_got, p_stop} = {sp0, sp1, si1, got, stop};
		{p_efp, p_i5} = {efp, state.i5};
		{s_zg, s_zw} = {zg, rsp.zw};
		p_idle = !(zwzg_t & (rd ^ wr));
		p_awset = (exp_parz | exp_p0) & ~(zwzg_t & state.i3 & op.sp);
	endtask

	task automatic wait_got(int limit);
		int n;
		n = 0;
		do begin
			tick();
			n++;
		end while (!got && n < limit);
		if (!got) begin
			$display("Timeout: no got within %0d cycles", limit);
			errors++;
		end
	endtask

	initial begin
		int e0;
		int i;
		void'($urandom(32'h3896c76e));
		repeat (10) tick();
		in_reset = 0;
		clo_req = 1'b0;	// Released on the next rising edge
		tick();
		check("state", STATE_RESET, state);
		check("got", 0, got);
		$display("test reset: done, errors=%0d", errors);
		e0 = errors;
		wait_got(60);
		par_on = 1'b1;
		for (i = 0; i < 400; i++) wait_got(60);
		par_on = 1'b0;
		$display("test random cycles: done, alarms=%0d errors=%0d", alarms, errors - e0);
		e0 = errors;
		mode_req = 1'b1;
		wait_got(60);
		for (i = 0; i < 4; i++) begin
			repeat (12) begin
				tick();
				check("got.parked", 0, got);
			end
			step_req = 1'b1;
			tick();
			step_req = 1'b0;
			wait_got(60);
		end
		mode_req = 1'b0;
		$display("test step mode: done, errors=%0d", errors - e0);
		e0 = errors;
		stop_req = 1'b1;	// Clear alarms left from parity errors
		tick();
		stop_req = 1'b0;
		tick();
		for (i = 0; i < 4000 && !awaria; i++) tick();
		if (!awaria) begin
			$display("Timeout: alarm never raised");
			errors++;
		end
		stop_req = 1'b1;
		tick();
		stop_req = 1'b0;
		repeat (2) tick();
		$display("test alarm and stop: done, errors=%0d", errors - e0);
		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
logic/cpu_state_pkg.sv
logic/sys_bus_pkg.sv
logic/strobgen.sv
logic/px.sv
logic/ifctl.sv
logic/cpu_ctl.sv
testbench/cpu_ctl_sva.sv
testbench/cpu_ctl_tb.sv

/* Bender.yml */
package:
  name: cpu_ctl

sources:
  - logic/cpu_state_pkg.sv
  - logic/sys_bus_pkg.sv
  - logic/strobgen.sv
  - logic/px.sv
  - logic/ifctl.sv
  - logic/cpu_ctl.sv
  - target: simulation
    files:
      - testbench/cpu_ctl_sva.sv
      - testbench/cpu_ctl_tb.sv
